/* verilog/valu_other_pkg.sv */
package valu_other_pkg;

  // element and scalar widths
  localparam int byte_width  = 8;
  localparam int hword_width = 16;
  localparam int word_width  = 32;
  localparam int xlen        = 32;

  localparam int rob_idx_width = 4;
  localparam int uop_idx_width = 3;
  localparam int reg_idx_width = 5;

  typedef enum logic [2:0] {
    opivv = 3'b000,
    opmvv = 3'b010,
    opivi = 3'b011,
    opivx = 3'b100,
    opmvx = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    vminu      = 6'b000100,
    vmin       = 6'b000101,
    vmaxu      = 6'b000110,
    vmax       = 6'b000111,
    vxunary0   = 6'b010010,
    vmerge_vmv = 6'b010111
  } funct6_e;

  // vs1 field reused as sub-opcode under vxunary0
  typedef enum logic [reg_idx_width-1:0] {
    vzext_vf4 = 5'b00100,
    vsext_vf4 = 5'b00101,
    vzext_vf2 = 5'b00110,
    vsext_vf2 = 5'b00111
  } xunary_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  typedef enum logic [1:0] {
    op_none       = 2'b00,
    op_minmax     = 2'b01,
    op_move_merge = 2'b10,
    op_extend     = 2'b11
  } op_class_e;

  typedef union packed {
    logic [word_width/byte_width-1:0][byte_width-1:0]   b;
    logic [word_width/hword_width-1:0][hword_width-1:0] h;
    logic [word_width-1:0]                              w;
  } lane_word_u;

endpackage

/* verilog/alu_other_decode.sv */
`timescale 1ns/1ps

module alu_other_decode (
  input  logic                      alu_uop_valid,
  input  valu_other_pkg::funct3_e   funct3,
  input  valu_other_pkg::funct6_e   funct6,
  input  logic                      vm,
  input  valu_other_pkg::xunary_e   vs1,
  input  logic                      vs1_data_valid,
  input  logic                      vs2_data_valid,
  input  logic                      rs1_data_valid,
  input  logic                      v0_data_valid,
  input  valu_other_pkg::eew_e      vs2_eew,
  output valu_other_pkg::op_class_e op_class,
  output logic                      minmax_max,
  output logic                      minmax_signed,
  output logic                      result_valid,
  output logic                      result_ignore_vma
);
  import valu_other_pkg::*;

  logic src1_valid;
  logic ext_width_ok;
  logic class_valid;

  // vector form reads vs1 while scalar and immediate forms come in on rs1
  assign src1_valid = (funct3 == opivv) ? vs1_data_valid : rs1_data_valid;

  // vf4 only from bytes and vf2 from bytes or halfwords
  assign ext_width_ok = (vs1 == vzext_vf4 || vs1 == vsext_vf4) ? (vs2_eew == eew8) :
                        (vs2_eew == eew8 || vs2_eew == eew16);

  always_comb begin
    op_class      = op_none;
    minmax_max    = 1'b0;
    minmax_signed = 1'b0;
    case (funct6)
      vminu, vmin, vmaxu, vmax: begin
        if (funct3 == opivv || funct3 == opivx) begin
          op_class      = op_minmax;
          minmax_max    = (funct6 == vmaxu) || (funct6 == vmax);
          minmax_signed = (funct6 == vmin) || (funct6 == vmax);
        end
      end
      vmerge_vmv: begin
        if (funct3 == opivv || funct3 == opivx || funct3 == opivi) begin
          op_class = op_move_merge;
        end
      end
      vxunary0: begin
        if (funct3 == opmvv && (vs1 inside {vzext_vf4, vsext_vf4, vzext_vf2, vsext_vf2})) begin
          op_class = op_extend;
        end
      end
      default: op_class = op_none;
    endcase
  end

  always_comb begin
    case (op_class)
      op_minmax:     class_valid = src1_valid & vs2_data_valid;
      op_move_merge: class_valid = src1_valid & (vm | (vs2_data_valid & v0_data_valid));
      op_extend:     class_valid = ~vs1_data_valid & vs2_data_valid & ext_width_ok;
      default:       class_valid = 1'b0;
    endcase
  end

  assign result_valid      = alu_uop_valid & class_valid;
  // only vmerge leaves masked-off elements to the unit
  assign result_ignore_vma = result_valid & (op_class == op_move_merge) & ~vm;

endmodule

/* verilog/alu_other_operand.sv */
`timescale 1ns/1ps

module alu_other_operand #(
  parameter int VLEN = 128
) (
  input  valu_other_pkg::op_class_e                 op_class,
  input  valu_other_pkg::funct3_e                   funct3,
  input  logic                                      vm,
  input  valu_other_pkg::xunary_e                   vs1,
  input  logic [VLEN-1:0]                           vs1_data,
  input  logic [VLEN-1:0]                           vs2_data,
  input  logic [valu_other_pkg::xlen-1:0]           rs1_data,
  input  logic [VLEN-1:0]                           v0_data,
  input  valu_other_pkg::eew_e                      vd_eew,
  input  valu_other_pkg::eew_e                      vs2_eew,
  input  logic [valu_other_pkg::uop_idx_width-1:0]  uop_index,
  output logic [VLEN-1:0]                           src1_data,
  output logic [VLEN-1:0]                           src2_data,
  output logic [VLEN/valu_other_pkg::byte_width-1:0] mask_bits
);
  import valu_other_pkg::*;

  localparam int vlenb = VLEN / byte_width;

  eew_e            scalar_eew;
  logic [VLEN-1:0] scalar_rep;
  logic            is_vf4;
  int unsigned     mask_base;

  // vmv.v writes at the destination width
  assign scalar_eew = (op_class == op_move_merge && vm) ? vd_eew : vs2_eew;
  assign is_vf4     = (vs1 == vzext_vf4) || (vs1 == vsext_vf4);

  always_comb begin
    case (scalar_eew)
      eew8:    scalar_rep = {(VLEN/byte_width){rs1_data[byte_width-1:0]}};
      eew16:   scalar_rep = {(VLEN/hword_width){rs1_data[hword_width-1:0]}};
      eew32:   scalar_rep = {(VLEN/word_width){rs1_data[word_width-1:0]}};
      default: scalar_rep = '0;
    endcase
  end

  always_comb begin
    src1_data = '0;
    if (op_class == op_minmax || op_class == op_move_merge) begin
      src1_data = (funct3 == opivv) ? vs1_data : scalar_rep;
    end
  end

  // extension source is the addressed half or quarter copied across the register
  always_comb begin
    case (op_class)
      op_minmax, op_move_merge: src2_data = vs2_data;
      op_extend: begin
        if (is_vf4) begin
          src2_data = {4{vs2_data[uop_index[1:0]*(VLEN/4) +: VLEN/4]}};
        end else begin
          src2_data = {2{vs2_data[uop_index[0]*(VLEN/2) +: VLEN/2]}};
        end
      end
      default: src2_data = '0;
    endcase
  end

  always_comb begin
    case (vs2_eew)
      eew8:    mask_base = uop_index * (VLEN/byte_width);
      eew16:   mask_base = uop_index * (VLEN/hword_width);
      eew32:   mask_base = uop_index * (VLEN/word_width);
      default: mask_base = 0;
    endcase
  end

  assign mask_bits = v0_data[mask_base +: vlenb];

endmodule

/* verilog/alu_other_minmax.sv */
`timescale 1ns/1ps

module alu_other_minmax #(
  parameter int VLEN = 128
) (
  input  logic [VLEN-1:0]      src1_data,
  input  logic [VLEN-1:0]      src2_data,
  input  valu_other_pkg::eew_e vs2_eew,
  input  logic                 minmax_max,
  input  logic                 minmax_signed,
  output logic [VLEN-1:0]      minmax_data
);
  import valu_other_pkg::*;

  localparam int lanes = VLEN / word_width;

  // operands arrive already widened, so one signed compare serves all modes
  function automatic logic [word_width:0] pick(
    input logic signed [word_width:0] a,
    input logic signed [word_width:0] b,
    input logic                       take_max
  );
    logic a_lt_b;
    a_lt_b = a < b;
    return (a_lt_b ^ take_max) ? a : b;
  endfunction

  for (genvar j = 0; j < lanes; j++) begin : g_lane
    lane_word_u op1;
    lane_word_u op2;
    lane_word_u res;

    assign op1 = src1_data[j*word_width +: word_width];
    assign op2 = src2_data[j*word_width +: word_width];

    always_comb begin
      logic [word_width:0] x;
      logic [word_width:0] y;
      res = '0;
      case (vs2_eew)
        eew8: begin
          for (int i = 0; i < word_width/byte_width; i++) begin
            x = {{(word_width-byte_width+1){minmax_signed & op1.b[i][byte_width-1]}}, op1.b[i]};
            y = {{(word_width-byte_width+1){minmax_signed & op2.b[i][byte_width-1]}}, op2.b[i]};
            res.b[i] = byte_width'(pick(x, y, minmax_max));
          end
        end
        eew16: begin
          for (int i = 0; i < word_width/hword_width; i++) begin
            x = {{(word_width-hword_width+1){minmax_signed & op1.h[i][hword_width-1]}}, op1.h[i]};
            y = {{(word_width-hword_width+1){minmax_signed & op2.h[i][hword_width-1]}}, op2.h[i]};
            res.h[i] = hword_width'(pick(x, y, minmax_max));
          end
        end
        eew32: begin
          x = {minmax_signed & op1.w[word_width-1], op1.w};
          y = {minmax_signed & op2.w[word_width-1], op2.w};
          res.w = word_width'(pick(x, y, minmax_max));
        end
        default: res = '0;
      endcase
    end

    assign minmax_data[j*word_width +: word_width] = res;
  end

endmodule

/* verilog/alu_other_extend.sv */
`timescale 1ns/1ps

module alu_other_extend #(
  parameter int VLEN = 128
) (
  input  logic [VLEN-1:0]         src2_data,
  input  valu_other_pkg::xunary_e vs1,
  input  valu_other_pkg::eew_e    vs2_eew,
  output logic [VLEN-1:0]         extend_data
);
  import valu_other_pkg::*;

  localparam int lanes = VLEN / word_width;

  logic sext;

  assign sext = (vs1 == vsext_vf2) || (vs1 == vsext_vf4);

  for (genvar j = 0; j < lanes; j++) begin : g_lane
    // output word j is fed by halfword j (vf2) or byte j (vf4)
    logic [hword_width-1:0] pair;
    logic [byte_width-1:0]  single;
    lane_word_u             res;

    assign pair   = src2_data[j*hword_width +: hword_width];
    assign single = src2_data[j*byte_width +: byte_width];

    always_comb begin
      res = '0;
      case (vs1)
        vzext_vf2, vsext_vf2: begin
          if (vs2_eew == eew8) begin
            for (int i = 0; i < 2; i++) begin
              res.h[i] = {{byte_width{sext & pair[(i+1)*byte_width-1]}},
                          pair[i*byte_width +: byte_width]};
            end
          end else if (vs2_eew == eew16) begin
            res.w = {{hword_width{sext & pair[hword_width-1]}}, pair};
          end
        end
        vzext_vf4, vsext_vf4: begin
          if (vs2_eew == eew8) begin
            res.w = {{(word_width-byte_width){sext & single[byte_width-1]}}, single};
          end
        end
        default: res = '0;
      endcase
    end

    assign extend_data[j*word_width +: word_width] = res;
  end

endmodule

/* verilog/alu_other_result.sv */
`timescale 1ns/1ps

module alu_other_result #(
  parameter int VLEN = 128
) (
  input  valu_other_pkg::op_class_e                  op_class,
  input  logic                                       vm,
  input  valu_other_pkg::eew_e                       vs2_eew,
  input  logic [VLEN-1:0]                            src1_data,
  input  logic [VLEN-1:0]                            src2_data,
  input  logic [VLEN/valu_other_pkg::byte_width-1:0] mask_bits,
  input  logic [VLEN-1:0]                            minmax_data,
  input  logic [VLEN-1:0]                            extend_data,
  output logic [VLEN-1:0]                            result_w_data
);
  import valu_other_pkg::*;

  localparam int lanes = VLEN / word_width;
  localparam int bpw   = word_width / byte_width;
  localparam int hpw   = word_width / hword_width;

  logic [VLEN-1:0] merge_data;

  for (genvar j = 0; j < lanes; j++) begin : g_lane
    lane_word_u s1;
    lane_word_u s2;
    lane_word_u m;

    assign s1 = src1_data[j*word_width +: word_width];
    assign s2 = src2_data[j*word_width +: word_width];

    // set mask bit takes the vs1/scalar element
    always_comb begin
      m = '0;
      case (vs2_eew)
        eew8: begin
          for (int i = 0; i < bpw; i++) begin
            m.b[i] = mask_bits[bpw*j+i] ? s1.b[i] : s2.b[i];
          end
        end
        eew16: begin
          for (int i = 0; i < hpw; i++) begin
            m.h[i] = mask_bits[hpw*j+i] ? s1.h[i] : s2.h[i];
          end
        end
        eew32:   m.w = mask_bits[j] ? s1.w : s2.w;
        default: m = '0;
      endcase
    end

    assign merge_data[j*word_width +: word_width] = m;
  end

  always_comb begin
    case (op_class)
      op_minmax:     result_w_data = minmax_data;
      op_move_merge: result_w_data = vm ? src1_data : merge_data;
      op_extend:     result_w_data = extend_data;
      default:       result_w_data = '0;
    endcase
  end

endmodule

/* verilog/rvv_alu_unit_other.sv */
`timescale 1ns/1ps

module rvv_alu_unit_other #(
  parameter int VLEN = 128
) (
  input  logic                                     alu_uop_valid,
  input  valu_other_pkg::funct3_e                  funct3,
  input  valu_other_pkg::funct6_e                  funct6,
  input  logic                                     vm,
  input  valu_other_pkg::xunary_e                  vs1,
  input  logic [VLEN-1:0]                          vs1_data,
  input  logic                                     vs1_data_valid,
  input  logic [VLEN-1:0]                          vs2_data,
  input  logic                                     vs2_data_valid,
  input  logic [valu_other_pkg::xlen-1:0]          rs1_data,
  input  logic                                     rs1_data_valid,
  input  logic [VLEN-1:0]                          v0_data,
  input  logic                                     v0_data_valid,
  input  valu_other_pkg::eew_e                     vd_eew,
  input  valu_other_pkg::eew_e                     vs2_eew,
  input  logic [valu_other_pkg::uop_idx_width-1:0] uop_index,
  input  logic [valu_other_pkg::rob_idx_width-1:0] rob_entry,
  output logic                                     result_valid,
  output logic [valu_other_pkg::rob_idx_width-1:0] result_rob_entry,
  output logic [VLEN-1:0]                          result_w_data,
  output logic                                     result_ignore_vma
);
  import valu_other_pkg::*;

  op_class_e              op_class;
  logic                   minmax_max;
  logic                   minmax_signed;
  logic [VLEN-1:0]        src1_data;
  logic [VLEN-1:0]        src2_data;
  logic [VLEN/byte_width-1:0] mask_bits;
  logic [VLEN-1:0]        minmax_data;
  logic [VLEN-1:0]        extend_data;

  alu_other_decode i_decode (
    .alu_uop_valid     (alu_uop_valid),
    .funct3            (funct3),
    .funct6            (funct6),
    .vm                (vm),
    .vs1               (vs1),
    .vs1_data_valid    (vs1_data_valid),
    .vs2_data_valid    (vs2_data_valid),
    .rs1_data_valid    (rs1_data_valid),
    .v0_data_valid     (v0_data_valid),
    .vs2_eew           (vs2_eew),
    .op_class          (op_class),
    .minmax_max        (minmax_max),
    .minmax_signed     (minmax_signed),
    .result_valid      (result_valid),
    .result_ignore_vma (result_ignore_vma)
  );

  alu_other_operand #(.VLEN(VLEN)) i_operand (
    .op_class  (op_class),
    .funct3    (funct3),
    .vm        (vm),
    .vs1       (vs1),
    .vs1_data  (vs1_data),
    .vs2_data  (vs2_data),
    .rs1_data  (rs1_data),
    .v0_data   (v0_data),
    .vd_eew    (vd_eew),
    .vs2_eew   (vs2_eew),
    .uop_index (uop_index),
    .src1_data (src1_data),
    .src2_data (src2_data),
    .mask_bits (mask_bits)
  );

  alu_other_minmax #(.VLEN(VLEN)) i_minmax (
    .src1_data     (src1_data),
    .src2_data     (src2_data),
    .vs2_eew       (vs2_eew),
    .minmax_max    (minmax_max),
    .minmax_signed (minmax_signed),
    .minmax_data   (minmax_data)
  );

  alu_other_extend #(.VLEN(VLEN)) i_extend (
    .src2_data   (src2_data),
    .vs1         (vs1),
    .vs2_eew     (vs2_eew),
    .extend_data (extend_data)
  );

  alu_other_result #(.VLEN(VLEN)) i_result (
    .op_class      (op_class),
    .vm            (vm),
    .vs2_eew       (vs2_eew),
    .src1_data     (src1_data),
    .src2_data     (src2_data),
    .mask_bits     (mask_bits),
    .minmax_data   (minmax_data),
    .extend_data   (extend_data),
    .result_w_data (result_w_data)
  );

  assign result_rob_entry = rob_entry;

endmodule

/* dv/alu_other_vectors.svh */
// columns are funct3, funct6, vs1 sub-opcode, vm, vd_eew, vs2_eew, uop_index,
//   valids {alu_uop, vs1, vs2, rs1, v0} and expected {result_valid, result_ignore_vma}
// vs1 sub-opcode only matters under vxunary0
task automatic load_vectors();
  // min/max
  add_row(opivv, vminu,      vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b11100, 2'b10);
  add_row(opivv, vmin,       vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b11100, 2'b10);
  add_row(opivx, vmaxu,      vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b10110, 2'b10);
  add_row(opivx, vmax,       vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b10110, 2'b10);
  add_row(opivv, vmax,       vzext_vf4, 1'b0, eew16, eew16, 3'd0, 5'b11100, 2'b10);
  add_row(opivx, vminu,      vzext_vf4, 1'b0, eew16, eew16, 3'd0, 5'b10110, 2'b10);
  add_row(opivv, vmaxu,      vzext_vf4, 1'b0, eew32, eew32, 3'd0, 5'b11100, 2'b10);
  add_row(opivx, vmin,       vzext_vf4, 1'b0, eew32, eew32, 3'd0, 5'b10110, 2'b10);
  // merge and move
  add_row(opivv, vmerge_vmv, vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b11101, 2'b11);
  add_row(opivx, vmerge_vmv, vzext_vf4, 1'b0, eew16, eew16, 3'd1, 5'b10111, 2'b11);
  add_row(opivi, vmerge_vmv, vzext_vf4, 1'b0, eew32, eew32, 3'd2, 5'b10111, 2'b11);
  add_row(opivx, vmerge_vmv, vzext_vf4, 1'b0, eew8,  eew8,  3'd7, 5'b10111, 2'b11);
  add_row(opivv, vmerge_vmv, vzext_vf4, 1'b1, eew8,  eew8,  3'd0, 5'b11000, 2'b10);
  add_row(opivx, vmerge_vmv, vzext_vf4, 1'b1, eew16, eew8,  3'd0, 5'b10010, 2'b10);
  add_row(opivi, vmerge_vmv, vzext_vf4, 1'b1, eew32, eew32, 3'd0, 5'b10010, 2'b10);
  // extension
  add_row(opmvv, vxunary0,   vzext_vf2, 1'b1, eew16, eew8,  3'd0, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vsext_vf2, 1'b1, eew16, eew8,  3'd1, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vzext_vf2, 1'b1, eew32, eew16, 3'd1, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vsext_vf2, 1'b1, eew32, eew16, 3'd0, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vzext_vf4, 1'b1, eew32, eew8,  3'd2, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vsext_vf4, 1'b1, eew32, eew8,  3'd3, 5'b10100, 2'b10);
  add_row(opmvv, vxunary0,   vsext_vf4, 1'b1, eew32, eew8,  3'd5, 5'b10100, 2'b10);
  // missing operands and illegal widths
  add_row(opivv, vmin,       vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b10100, 2'b00);
  add_row(opivx, vmax,       vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b10100, 2'b00);
  add_row(opivv, vmerge_vmv, vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b11100, 2'b00);
  add_row(opivx, vmerge_vmv, vzext_vf4, 1'b1, eew8,  eew8,  3'd0, 5'b10101, 2'b00);
  add_row(opmvv, vxunary0,   vsext_vf2, 1'b1, eew16, eew8,  3'd0, 5'b11100, 2'b00);
  add_row(opmvv, vxunary0,   vzext_vf4, 1'b1, eew32, eew16, 3'd0, 5'b10100, 2'b00);
  add_row(opmvv, vxunary0,   vsext_vf2, 1'b1, eew32, eew32, 3'd0, 5'b10100, 2'b00);
  add_row(opmvv, vminu,      vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b11111, 2'b00);
  // no micro-op
  add_row(opivv, vmin,       vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b01111, 2'b00);
  add_row(opivv, vmerge_vmv, vzext_vf4, 1'b0, eew8,  eew8,  3'd0, 5'b01111, 2'b00);
endtask

/* dv/tb_alu_unit_other.sv */
`timescale 1ns/1ps

module tb_alu_unit_other;
  import valu_other_pkg::*;

  localparam int vlen         = 128;
  localparam int clk_period   = 4;
  localparam int reset_cycles = 10;

  typedef struct packed {
    funct3_e    funct3;
    funct6_e    funct6;
    xunary_e    vs1;
    logic       vm;
    eew_e       vd_eew;
    eew_e       vs2_eew;
    logic [2:0] uop_index;
    // alu_uop, vs1, vs2, rs1, v0
    logic [4:0] valids;
    // result_valid, result_ignore_vma
    logic [1:0] exp_out;
  } vec_t;

  logic                     clk = 1'b0;
  logic                     reset = 1'b1;
  logic                     alu_uop_valid;
  funct3_e                  funct3;
  funct6_e                  funct6;
  logic                     vm;
  xunary_e                  vs1;
  logic [vlen-1:0]          vs1_data;
  logic                     vs1_data_valid;
  logic [vlen-1:0]          vs2_data;
  logic                     vs2_data_valid;
  logic [xlen-1:0]          rs1_data;
  logic                     rs1_data_valid;
  logic [vlen-1:0]          v0_data;
  logic                     v0_data_valid;
  eew_e                     vd_eew;
  eew_e                     vs2_eew;
  logic [uop_idx_width-1:0] uop_index;
  logic [rob_idx_width-1:0] rob_entry;
  logic                     result_valid;
  logic [rob_idx_width-1:0] result_rob_entry;
  logic [vlen-1:0]          result_w_data;
  logic                     result_ignore_vma;

  int   seed = 32'h31e2_49d6;
  bit   table_ready = 1'b0;
  vec_t vectors[$];

  rvv_alu_unit_other #(.VLEN(vlen)) i_dut (.*);

  always #(clk_period/2) clk = ~clk;

  initial begin
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

  task automatic add_row(funct3_e f3, funct6_e f6, xunary_e sub, logic m, eew_e vd,
                         eew_e vs2, logic [2:0] uop, logic [4:0] v, logic [1:0] e);
    vectors.push_back(vec_t'{f3, f6, sub, m, vd, vs2, uop, v, e});
  endtask

  `include "alu_other_vectors.svh"

  task automatic compare(string name, logic [vlen-1:0] actual, logic [vlen-1:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic int elem_bits(eew_e e);
    case (e)
      eew8:    return 8;
      eew16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic logic [31:0] get_elem(logic [vlen-1:0] v, int k, int w);
    logic [vlen-1:0] t;
    logic [63:0]     m;
    t = v >> (k * w);
    m = (64'd1 << w) - 64'd1;
    return t[31:0] & m[31:0];
  endfunction

  function automatic logic [vlen-1:0] put_elem(logic [vlen-1:0] v, int k, int w,
                                               logic [31:0] e);
    logic [63:0] m;
    m = (64'd1 << w) - 64'd1;
    return v | (vlen'(e & m[31:0]) << (k * w));
  endfunction

  // element value as a signed or unsigned number
  function automatic longint widen(logic [31:0] e, int w, bit sgn);
    if (sgn && e[w-1]) return longint'(e) - (longint'(1) << w);
    return longint'(e);
  endfunction

  function automatic logic [vlen-1:0] expected_data(vec_t r);
    logic [vlen-1:0] res;
    logic [vlen-1:0] s1;
    int              w;
    int              f;
    int              base;
    longint          a;
    longint          b;
    bit              sgn;
    res = '0;
    s1  = '0;
    if (r.funct6 == vxunary0) begin
      f    = (r.vs1 == vzext_vf4 || r.vs1 == vsext_vf4) ? 4 : 2;
      sgn  = (r.vs1 == vsext_vf2 || r.vs1 == vsext_vf4);
      w    = elem_bits(r.vs2_eew);
      base = (int'(r.uop_index) % f) * (vlen / f);
      for (int k = 0; k < vlen / (w * f); k++) begin
        a   = widen(get_elem(vs2_data >> base, k, w), w, sgn);
        res = put_elem(res, k, w * f, 32'(a));
      end
      return res;
    end
    // vmv.v takes the destination width and everything else the vs2 width
    w = (r.funct6 == vmerge_vmv && r.vm) ? elem_bits(r.vd_eew) : elem_bits(r.vs2_eew);
    if (r.funct3 == opivv) s1 = vs1_data;
    else for (int k = 0; k < vlen / w; k++) s1 = put_elem(s1, k, w, rs1_data);
    if (r.funct6 == vmerge_vmv) begin
      if (r.vm) return s1;
      for (int k = 0; k < vlen / w; k++) begin
        res = put_elem(res, k, w, v0_data[int'(r.uop_index) * (vlen / w) + k] ?
                                  get_elem(s1, k, w) : get_elem(vs2_data, k, w));
      end
      return res;
    end
    sgn = (r.funct6 == vmin || r.funct6 == vmax);
    for (int k = 0; k < vlen / w; k++) begin
      a = widen(get_elem(s1, k, w), w, sgn);
      b = widen(get_elem(vs2_data, k, w), w, sgn);
      if (r.funct6 == vmaxu || r.funct6 == vmax) res = put_elem(res, k, w, 32'(a > b ? a : b));
      else res = put_elem(res, k, w, 32'(a < b ? a : b));
    end
    return res;
  endfunction

  task automatic randomize_data();
    logic [4:0] imm;
    for (int i = 0; i < vlen / 32; i++) begin
      vs1_data[i*32 +: 32] = $random(seed);
      vs2_data[i*32 +: 32] = $random(seed);
      v0_data[i*32 +: 32]  = $random(seed);
    end
    imm       = 5'($random(seed));
    rs1_data  = (funct3 == opivi) ? {{27{imm[4]}}, imm} : $random(seed);
    rob_entry = 4'($random(seed));
  endtask

  task automatic apply_row(vec_t r);
    funct3         = r.funct3;
    funct6         = r.funct6;
    vs1            = r.vs1;
    vm             = r.vm;
    vd_eew         = r.vd_eew;
    vs2_eew        = r.vs2_eew;
    uop_index      = r.uop_index;
    {alu_uop_valid, vs1_data_valid, vs2_data_valid, rs1_data_valid, v0_data_valid} = r.valids;
    randomize_data();
  endtask

  initial begin
    alu_uop_valid  = 1'b0;
    funct3         = opivv;
    funct6         = vmin;
    vm             = 1'b0;
    vs1            = vzext_vf4;
    vs1_data_valid = 1'b1;
    vs2_data_valid = 1'b1;
    rs1_data_valid = 1'b1;
    v0_data_valid  = 1'b1;
    vd_eew         = eew8;
    vs2_eew        = eew8;
    uop_index      = '0;
    vs1_data       = '0;
    vs2_data       = '0;
    rs1_data       = '0;
    v0_data        = '0;
    rob_entry      = '0;
    load_vectors();
    table_ready = 1'b1;
    // idle during reset with operands present but no micro-op
    while (reset) begin
      @(posedge clk);
      #1;
      randomize_data();
      #2;
      compare("result_valid", vlen'(result_valid), '0);
      compare("result_ignore_vma", vlen'(result_ignore_vma), '0);
      compare("result_rob_entry", vlen'(result_rob_entry), vlen'(rob_entry));
    end
    foreach (vectors[i]) begin
      @(posedge clk);
      #1;
      apply_row(vectors[i]);
      #2;
      compare("result_valid", vlen'(result_valid), vlen'(vectors[i].exp_out[1]));
      compare("result_ignore_vma", vlen'(result_ignore_vma), vlen'(vectors[i].exp_out[0]));
      compare("result_rob_entry", vlen'(result_rob_entry), vlen'(rob_entry));
      if (vectors[i].exp_out[1]) begin
        compare("result_w_data", result_w_data, expected_data(vectors[i]));
      end
    end
    @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((vectors.size() + reset_cycles + 20) * clk_period);
    $display("watchdog: the run did not finish in time");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

/* sources.f */
+incdir+dv
verilog/valu_other_pkg.sv
verilog/alu_other_decode.sv
verilog/alu_other_operand.sv
verilog/alu_other_minmax.sv
verilog/alu_other_extend.sv
verilog/alu_other_result.sv
verilog/rvv_alu_unit_other.sv
dv/tb_alu_unit_other.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_alu_unit_other -o tb_alu_unit_other
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_alu_unit_other 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
echo "pass message not found"
exit 1
